/* hw/tr_fifo_pkg.sv */
// Token ring FIFO definitions
// Payload width, storage depth and capacity, shared types
// and the ring patterns each side loads on reset
package tr_fifo_pkg;

    // ******************************
    // Sizes
    // ******************************
    // Payload word width
    localparam int DATA_WIDTH = 10;
    // Storage slots and ring length
    localparam int FIFO_DEPTH = 8;
    // Two slots stay free as a guard for the ring pair
    localparam int FIFO_CAPACITY = FIFO_DEPTH - 2;

    // ******************************
    // Types
    // ******************************
    // Ring state or one-hot slot pointer
    typedef logic [FIFO_DEPTH-1:0] ring_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

    // ******************************
    // Ring reset patterns
    // ******************************
    // Write pair sits two places ahead of the read pair
    localparam ring_t WR_RING_RESET = ring_t'(4'b1100);
    localparam ring_t RD_RING_RESET = ring_t'(4'b0011);

endpackage

/* hw/tr_mem_if.sv */
// Storage port bundle of the token ring FIFO
// Write slot and word come from the write side
// Read slot comes from the read side and the array returns the word
`timescale 1ns/100ps

interface tr_mem_if import tr_fifo_pkg::*; ();

    // Write port, write clock domain
    logic  wr_en;
    ring_t wr_ptr;
    data_t wr_data;

    // Read port with one-hot select
    ring_t rd_ptr;
    // Combinational word out of the array
    data_t rd_data;

    modport din (output wr_en, output wr_ptr, output wr_data);

    modport mem (input wr_en, input wr_ptr, input wr_data, input rd_ptr, output rd_data);

    modport dout (output rd_ptr, input rd_data);

endinterface

/* hw/token_ring.sv */
// Token ring pointer register
// Holds two adjacent hot bits and rotates them one place
// toward the MSB on every enabled clock edge
`timescale 1ns/100ps

module token_ring import tr_fifo_pkg::*; #(
    parameter ring_t RESET_VALUE = RD_RING_RESET
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  enable,
    output ring_t state
);

    // ******************************
    // Ring register
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RESET_VALUE;
        end else if (enable) begin
            // MSB wraps back into bit 0
            state <= {state[FIFO_DEPTH-2:0], state[FIFO_DEPTH-1]};
        end
    end

    // ******************************
    // Checks
    // ******************************
    // Exactly two ones that touch
    // Bit 0 and the MSB count as neighbours
    a_ring_pair: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($countones(state) == 2) &&
        (|(state & {state[0], state[FIFO_DEPTH-1:1]}))
    ) else $error("token ring lost its adjacent pair %b", state);

endmodule

/* hw/bit_sync.sv */
// Ring synchronizer
// Two flop stages in the receiving clock domain carry the other
// side's ring state across the boundary
`timescale 1ns/100ps

module bit_sync import tr_fifo_pkg::*; #(
    // Opposite side's ring pattern after reset
    parameter ring_t RESET_VALUE = WR_RING_RESET
) (
    input  logic  clk,
    input  logic  rst_n,
    input  ring_t d_in,
    output ring_t d_out
);

    // First stage may go metastable
    ring_t meta;

    // Each ring step flips two bits
    // A split capture only widens or narrows the pair for one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta  <= RESET_VALUE;
            d_out <= RESET_VALUE;
        end else begin
            meta  <= d_in;
            // Second stage gives the first a full cycle to settle
            d_out <= meta;
        end
    end

endmodule

/* hw/tr_fifo_mem.sv */
// Token ring FIFO storage array
// Stores a word at the one-hot write slot on the write clock
// and returns the word at the one-hot read slot combinationally
`timescale 1ns/100ps

module tr_fifo_mem import tr_fifo_pkg::*; (
    // Write clock
    input logic   clk,
    tr_mem_if.mem mem
);

    // ******************************
    // Storage
    // ******************************
    data_t slots [FIFO_DEPTH];
    data_t rd_word;

    // One slot per accepted word
    always_ff @(posedge clk) begin
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            if (mem.wr_en && mem.wr_ptr[i]) begin
                slots[i] <= mem.wr_data;
            end
        end
    end

    // ******************************
    // Read mux
    // ******************************
    // AND-OR select on the one-hot read slot
    // Slots being written elsewhere do not disturb the output
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            if (mem.rd_ptr[i]) begin
                rd_word = rd_word | slots[i];
            end
        end
    end

    assign mem.rd_data = rd_word;

    // ******************************
    // Checks
    // ******************************
    // Write side must select exactly one slot
    a_wr_onehot: assert property (
        @(posedge clk) mem.wr_en |-> $onehot(mem.wr_ptr)
    ) else $error("write slot not one-hot %b", mem.wr_ptr);

endmodule

/* hw/tr_fifo_din.sv */
// Token ring FIFO write side
// Accepts words on valid/ready, steers the write slot from its ring
// and refuses words once the slot reaches the synchronized read pair
`timescale 1ns/100ps

module tr_fifo_din import tr_fifo_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  data_t wr_data,
    input  logic  wr_valid,
    output logic  wr_ready,
    // Write ring toward the read domain synchronizer
    output ring_t wr_ring,
    input  ring_t rd_ring_sync,
    tr_mem_if.din mem
);

    ring_t wr_slot;
    logic  push;

    // ******************************
    // Write pointer
    // ******************************
    token_ring #(
        .RESET_VALUE (WR_RING_RESET)
    ) wr_ring_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (push),
        .state  (wr_ring)
    );

    // Lower bit of the pair is the next slot to fill
    assign wr_slot = wr_ring & {wr_ring[0], wr_ring[FIFO_DEPTH-1:1]};

    // ******************************
    // Handshake
    // ******************************
    // Full when the slot meets the read guard pair
    // A lagging read ring only makes this earlier
    assign wr_ready = ~|(wr_slot & rd_ring_sync);
    assign push     = wr_valid & wr_ready;

    // Word and ring step land on the same edge
    assign mem.wr_en   = push;
    assign mem.wr_ptr  = wr_slot;
    assign mem.wr_data = wr_data;

    // ******************************
    // Checks
    // ******************************
    // A refused word stays offered and unchanged until taken
    a_wr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_data)
    ) else $error("write word dropped or changed before acceptance");

endmodule

/* hw/tr_fifo_dout.sv */
// Token ring FIFO read side
// Derives the read slot from its ring, raises valid once the
// synchronized write ring has moved past that slot
// and steps the ring on every pop
`timescale 1ns/100ps

module tr_fifo_dout import tr_fifo_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output data_t rd_data,
    output logic  rd_valid,
    input  logic  rd_ready,
    // Read ring toward the write domain synchronizer
    output ring_t rd_ring,
    input  ring_t wr_ring_sync,
    tr_mem_if.dout mem
);

    ring_t rd_low;
    ring_t rd_slot;
    logic  pop;

    // ******************************
    // Read pointer
    // ******************************
    token_ring #(
        .RESET_VALUE (RD_RING_RESET)
    ) rd_ring_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (pop),
        .state  (rd_ring)
    );

    // Lower bit of the pair as on the write side
    assign rd_low  = rd_ring & {rd_ring[0], rd_ring[FIFO_DEPTH-1:1]};
    // Two places on is the slot just above the pair
    // Starts level with the write slot
    assign rd_slot = {rd_low[FIFO_DEPTH-3:0], rd_low[FIFO_DEPTH-1:FIFO_DEPTH-2]};

    // ******************************
    // Handshake
    // ******************************
    // Empty while the write pair still covers the read slot
    assign rd_valid = ~|(rd_slot & wr_ring_sync);
    assign pop      = rd_valid & rd_ready;

    assign mem.rd_ptr = rd_slot;
    // Word comes straight out of the array
    assign rd_data    = mem.rd_data;

    // ******************************
    // Checks
    // ******************************
    a_rd_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(rd_slot)
    ) else $error("read slot not one-hot %b", rd_slot);

    // An offered word stays offered and unchanged until popped
    a_hold_until_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data)
    ) else $error("read word dropped or changed before pop");

endmodule

/* hw/tr_fifo_top.sv */
// Dual-clock token ring FIFO
// Carries words from the write clock domain to the read clock domain
// Each side checks full or empty against the other side's ring
// after a two-flop synchronizer
`timescale 1ns/100ps

module tr_fifo_top import tr_fifo_pkg::*; (
    // Write clock domain
    input  logic  clk_wr,
    input  logic  rst_n_wr,
    input  data_t wr_data,
    input  logic  wr_valid,
    output logic  wr_ready,
    // Read clock domain
    input  logic  clk_rd,
    input  logic  rst_n_rd,
    output data_t rd_data,
    output logic  rd_valid,
    input  logic  rd_ready
);

    ring_t wr_ring;
    ring_t rd_ring;
    // Rings as seen in the opposite domain
    ring_t wr_ring_sync;
    ring_t rd_ring_sync;

    tr_mem_if mem_bus ();

    // ******************************
    // Write domain
    // ******************************
    tr_fifo_din din_inst (
        .clk          (clk_wr),
        .rst_n        (rst_n_wr),
        .wr_data      (wr_data),
        .wr_valid     (wr_valid),
        .wr_ready     (wr_ready),
        .wr_ring      (wr_ring),
        .rd_ring_sync (rd_ring_sync),
        .mem          (mem_bus.din)
    );

    // Array is clocked by the writer
    tr_fifo_mem mem_inst (
        .clk (clk_wr),
        .mem (mem_bus.mem)
    );

    // Read ring into the write domain
    bit_sync #(
        .RESET_VALUE (RD_RING_RESET)
    ) rd_ring_sync_inst (
        .clk   (clk_wr),
        .rst_n (rst_n_wr),
        .d_in  (rd_ring),
        .d_out (rd_ring_sync)
    );

    // ******************************
    // Read domain
    // ******************************
    tr_fifo_dout dout_inst (
        .clk          (clk_rd),
        .rst_n        (rst_n_rd),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .rd_ready     (rd_ready),
        .rd_ring      (rd_ring),
        .wr_ring_sync (wr_ring_sync),
        .mem          (mem_bus.dout)
    );

    // Write ring into the read domain
    bit_sync #(
        .RESET_VALUE (WR_RING_RESET)
    ) wr_ring_sync_inst (
        .clk   (clk_rd),
        .rst_n (rst_n_rd),
        .d_in  (wr_ring),
        .d_out (wr_ring_sync)
    );

endmodule

/* sim/tr_fifo_checker.sv */
// Token ring FIFO monitor
// Records words at the write handshake, compares each popped word
// with the oldest outstanding one and watches the occupancy
`timescale 1ns/100ps

module tr_fifo_checker import tr_fifo_pkg::*; (
    input  logic                  clk_wr,
    input  logic                  rst_n_wr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  wr_valid,
    input  logic                  wr_ready,
    input  logic                  clk_rd,
    input  logic                  rst_n_rd,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_valid,
    input  logic                  rd_ready,
    output int                    error_count,
    output int                    accepted_count,
    output int                    popped_count,
    output int                    peak_count
);

    // Every accepted word in order, head sits at popped_count
    logic [DATA_WIDTH-1:0] expect_q[$];
    logic [DATA_WIDTH-1:0] expected;
    int wr_errors;
    int rd_errors;

    assign error_count = wr_errors + rd_errors;

    // ******************************
    // Write handshake
    // ******************************
    always @(posedge clk_wr) begin
        if (rst_n_wr && rst_n_rd && wr_valid && wr_ready) begin
            // A seventh word in flight means a slot got overwritten
            if (accepted_count - popped_count >= FIFO_CAPACITY) begin
                $display("write accepted at %0t with %0d words held, capacity %0d",
                         $time, accepted_count - popped_count, FIFO_CAPACITY);
                wr_errors++;
            end
            expect_q.push_back(wr_data);
            accepted_count = accepted_count + 1;
            // Highest fill seen so far
            if (accepted_count - popped_count > peak_count) begin
                peak_count = accepted_count - popped_count;
            end
        end
    end

    // ******************************
    // Read handshake
    // ******************************
    always @(posedge clk_rd) begin
        if (rst_n_wr && rst_n_rd && rd_valid) begin
            if (popped_count >= accepted_count) begin
                $display("rd_valid high at %0t with no accepted word outstanding", $time);
                rd_errors++;
            end else if (rd_ready) begin
                expected = expect_q[popped_count];
                if (rd_data !== expected) begin
                    $display("MISMATCH at %0t: expected %h, got %h", $time, expected, rd_data);
                    rd_errors++;
                end
                popped_count = popped_count + 1;
            end
        end
    end

endmodule

/* sim/tr_fifo_tb.sv */
// Token ring FIFO testbench
// Two asynchronous clocks, stimulus from a data file, write and read
// drivers on falling edges, a watchdog and a per-test report
`timescale 1ns/100ps

module tr_fifo_tb import tr_fifo_pkg::*; ();

    localparam int CLK_HALF       = 4;
    localparam int RD_PHASE       = 3;
    localparam int RESET_CYCLES   = 4;
    localparam int CYCLES_PER_WORD = 64;
    localparam int DRAIN_CYCLES   = 10;

    logic clk_wr;
    logic rst_n_wr;
    logic wr_valid;
    logic wr_ready;
    logic clk_rd;
    logic rst_n_rd;
    logic rd_valid;
    logic rd_ready;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [DATA_WIDTH-1:0] rd_data;

    // One entry per stimulus line
    int test_q[$];
    logic [DATA_WIDTH-1:0] word_q[$];
    int gap_q[$];
    int stall_q[$];

    int n_words;
    int refusals;
    int pass_count;
    int fail_count;
    logic [31:0] rng_state;
    int error_count;
    int accepted_count;
    int popped_count;
    int peak_count;

    tr_fifo_top tr_fifo_top_inst (
        .clk_wr (clk_wr), .rst_n_wr (rst_n_wr), .wr_data (wr_data),
        .wr_valid (wr_valid), .wr_ready (wr_ready),
        .clk_rd (clk_rd), .rst_n_rd (rst_n_rd), .rd_data (rd_data),
        .rd_valid (rd_valid), .rd_ready (rd_ready)
    );

    tr_fifo_checker checker_inst (
        .clk_wr (clk_wr), .rst_n_wr (rst_n_wr), .wr_data (wr_data),
        .wr_valid (wr_valid), .wr_ready (wr_ready),
        .clk_rd (clk_rd), .rst_n_rd (rst_n_rd), .rd_data (rd_data),
        .rd_valid (rd_valid), .rd_ready (rd_ready),
        .error_count (error_count), .accepted_count (accepted_count),
        .popped_count (popped_count), .peak_count (peak_count)
    );

    // ******************************
    // Clocks
    // ******************************
    initial begin
        clk_wr = 1'b0;
        forever #(CLK_HALF) clk_wr = ~clk_wr;
    end

    // Same period, shifted so no edges coincide
    initial begin
        clk_rd = 1'b0;
        #(RD_PHASE);
        forever #(CLK_HALF) clk_rd = ~clk_rd;
    end

    // ******************************
    // Helpers
    // ******************************
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Lines that do not parse as four columns are comments
    task load_stimulus(output bit opened);
        int fd;
        int code;
        int t_num;
        int t_gap;
        int t_stall;
        logic [31:0] t_data;
        logic [8*128-1:0] skipped;
        fd = $fopen("sim/tr_fifo_stim.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%d %h %d %d\n", t_num, t_data, t_gap, t_stall);
                if (code == 4) begin
                    test_q.push_back(t_num);
                    word_q.push_back(t_data[DATA_WIDTH-1:0]);
                    gap_q.push_back(t_gap);
                    stall_q.push_back(t_stall);
                end else begin
                    code = $fgets(skipped, fd);
                end
            end
            $fclose(fd);
        end
        n_words = test_q.size();
    endtask

    task report_test(input string name, input bit ok);
        $display("test %s: %s", name, ok ? "ok" : "FAILED");
        if (ok) pass_count++;
        else fail_count++;
    endtask

    task release_wr_reset;
        repeat (RESET_CYCLES) @(posedge clk_wr);
        @(negedge clk_wr);
        rst_n_wr = 1'b1;
    endtask

    task release_rd_reset;
        repeat (RESET_CYCLES) @(posedge clk_rd);
        @(negedge clk_rd);
        rst_n_rd = 1'b1;
    endtask

    // ******************************
    // Drivers
    // ******************************
    // Ready sampled at the falling edge holds until the next rising edge
    task drive_writes;
        bit taken;
        for (int i = 0; i < n_words; i++) begin
            if (gap_q[i] > 0) begin
                wr_valid = 1'b0;
                repeat (gap_q[i]) @(negedge clk_wr);
            end
            wr_valid = 1'b1;
            wr_data  = word_q[i];
            taken    = 1'b0;
            while (!taken) begin
                taken = wr_ready;
                // Refused word stays on the bus
                if (!taken) refusals++;
                @(negedge clk_wr);
            end
        end
        wr_valid = 1'b0;
    endtask

    // Stall before each pop, then hold ready until the word leaves
    task drive_reads;
        int stall;
        int mark;
        bit popped;
        mark = error_count;
        // Read side moves on read clock falling edges only
        @(negedge clk_rd);
        for (int i = 0; i < n_words; i++) begin
            if (stall_q[i] < 0) begin
                rng_state = next_random(rng_state);
                stall = int'(rng_state % 5);
            end else begin
                stall = stall_q[i];
            end
            rd_ready = 1'b0;
            repeat (stall) @(negedge clk_rd);
            rd_ready = 1'b1;
            popped = 1'b0;
            while (!popped) begin
                popped = rd_valid;
                @(negedge clk_rd);
            end
            // Last word of a test closes it
            if (i == n_words - 1 || test_q[i+1] != test_q[i]) begin
                report_test($sformatf("%0d", test_q[i]), error_count == mark);
                mark = error_count;
            end
        end
        rd_ready = 1'b0;
    endtask

    // ******************************
    // Watchdog
    // ******************************
    initial begin
        #1;
        repeat (n_words * CYCLES_PER_WORD + RESET_CYCLES) @(posedge clk_wr);
        $display("run stalled: %0d words still outstanding", n_words - popped_count);
        $display("=== FAIL ===");
        $finish;
    end

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        bit opened;
        bit ok;
        bit drain_high;
        int mark;
        rst_n_wr   = 1'b0;
        rst_n_rd   = 1'b0;
        wr_valid   = 1'b0;
        wr_data    = '0;
        rd_ready   = 1'b0;
        refusals   = 0;
        pass_count = 0;
        fail_count = 0;
        rng_state  = 32'h1fae;
        load_stimulus(opened);
        if (!opened) begin
            $display("could not open stimulus file sim/tr_fifo_stim.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            fork
                release_wr_reset();
                release_rd_reset();
            join
            // Empty and ready once both sides are out of reset
            @(negedge clk_wr);
            report_test("reset", rd_valid === 1'b0 && wr_ready === 1'b1);
            fork
                drive_writes();
                drive_reads();
            join
            // Everything accepted came out and the FIFO stays empty
            mark = error_count;
            ok = 1'b1;
            if (accepted_count != n_words || popped_count != n_words) begin
                $display("accepted %0d and delivered %0d words, stimulus has %0d",
                         accepted_count, popped_count, n_words);
                ok = 1'b0;
            end
            if (refusals == 0) begin
                $display("write side never refused a word, capacity was not reached");
                ok = 1'b0;
            end
            if (peak_count != FIFO_CAPACITY) begin
                $display("FIFO held at most %0d words, capacity is %0d",
                         peak_count, FIFO_CAPACITY);
                ok = 1'b0;
            end
            drain_high = 1'b0;
            repeat (DRAIN_CYCLES) begin
                @(negedge clk_rd);
                if (rd_valid !== 1'b0) drain_high = 1'b1;
            end
            if (drain_high) begin
                $display("rd_valid came back high after the last pop");
                ok = 1'b0;
            end
            report_test("drain", ok && error_count == mark);
            $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

/* sim/tr_fifo_stim.txt */
# columns: test number, data word in hex, write gap, read stall
# gaps in write cycles before the word, stalls in read cycles before its pop, -1 for random
1 2a5 3 0
1 0f1 0 2
1 3c0 5 0
1 155 1 4
2 311 2 60
2 0a2 0 0
2 1b3 0 0
2 2c4 0 0
2 3d5 0 0
2 0e6 0 0
2 1f7 0 0
2 208 0 0
2 319 0 0
3 3ff 20 -1
3 000 0 -1
3 2aa 1 -1
3 155 0 -1
3 07e 3 -1
3 381 0 -1
3 19c 0 -1
3 263 2 -1
3 0d4 0 -1
3 32b 1 -1
3 1e0 0 -1
3 21f 0 -1
3 04c 4 -1

/* list.f */
hw/tr_fifo_pkg.sv
hw/tr_mem_if.sv
hw/token_ring.sv
hw/bit_sync.sv
hw/tr_fifo_mem.sv
hw/tr_fifo_din.sv
hw/tr_fifo_dout.sv
hw/tr_fifo_top.sv
sim/tr_fifo_checker.sv
sim/tr_fifo_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tr_fifo_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
PASS_MSG  = === PASS ===

.PHONY: run clean

# Exit status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
